/* common/lcd_pkg.sv */
package lcd_pkg;

	typedef logic [7:0] lcd_data_t;   // parallel data bus
	typedef logic [9:0] lcd_word_t;   // {rs, rw, data}
	typedef logic [6:0] ddram_addr_t; // display RAM address
	typedef logic [7:0] char_t;       // character code
	typedef logic       row_t;        // line 0 or line 1
	typedef logic [5:0] col_t;        // column on a line

	// flag order: lines, font, display on, cursor, blink, increment, shift
	typedef logic [6:0] init_flags_t;

	// HD44780 instruction prefixes
	localparam lcd_data_t cmd_clear        = 8'h01;
	localparam lcd_data_t cmd_entry_mode   = 8'h04; // I/D in bit 1, S in bit 0
	localparam lcd_data_t cmd_display_ctrl = 8'h08; // D, C, B in bits 2..0
	localparam lcd_data_t cmd_function_set = 8'h30; // 8-bit bus, N and F in bits 3..2
	localparam lcd_data_t cmd_set_ddram    = 8'h80; // address in bits 6..0

	localparam ddram_addr_t line1_base = 7'h40; // first cell of the second line

endpackage

/* common/arb_pkg.sv */
package arb_pkg;

	typedef logic client_t; // index of a text client

	typedef enum logic [2:0] {
		arb_idle,    // no grant held
		arb_grant,   // grant held, waiting for a word
		arb_issue,   // enable sent, waiting for busy
		arb_wait,    // driver working on the word
		arb_release  // word_ack high until word_req drops
	} arb_state_t;

endpackage

/* lcd_driver/lcd_driver.sv */
`timescale 1ns/1ps

module lcd_driver #(
	parameter int                   clk_per_us = 50,
	parameter lcd_pkg::init_flags_t init_flags = 7'b1010010
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               lcd_enable,
	input  lcd_pkg::lcd_word_t lcd_bus,
	output logic               busy,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output lcd_pkg::lcd_data_t lcd_data
);

	localparam int cnt_w = $clog2(500 * clk_per_us + 1);

	typedef logic [cnt_w-1:0] cnt_t;

	typedef enum logic [1:0] {
		drv_power_up = 2'd0,
		drv_init     = 2'd1,
		drv_ready    = 2'd2,
		drv_write    = 2'd3
	} drv_state_t;

	localparam cnt_t t_power     = cnt_t'(500 * clk_per_us);
	localparam cnt_t t_fset_end  = cnt_t'(10 * clk_per_us);
	localparam cnt_t t_gap1_end  = cnt_t'(60 * clk_per_us);
	localparam cnt_t t_ctrl_end  = cnt_t'(70 * clk_per_us);
	localparam cnt_t t_gap2_end  = cnt_t'(120 * clk_per_us);
	localparam cnt_t t_clr_end   = cnt_t'(130 * clk_per_us);
	localparam cnt_t t_gap3_end  = cnt_t'(330 * clk_per_us);
	localparam cnt_t t_entry_end = cnt_t'(340 * clk_per_us);
	localparam cnt_t t_init_end  = cnt_t'(440 * clk_per_us);
	localparam cnt_t t_e_rise    = cnt_t'(clk_per_us);
	localparam cnt_t t_e_fall    = cnt_t'(14 * clk_per_us);
	localparam cnt_t t_write_end = cnt_t'(50 * clk_per_us);

	localparam lcd_pkg::lcd_data_t fset_cmd =
		lcd_pkg::cmd_function_set | {4'b0000, init_flags[6:5], 2'b00};
	localparam lcd_pkg::lcd_data_t ctrl_cmd =
		lcd_pkg::cmd_display_ctrl | {5'b00000, init_flags[4:2]};
	localparam lcd_pkg::lcd_data_t entry_cmd =
		lcd_pkg::cmd_entry_mode | {6'b000000, init_flags[1:0]};

	drv_state_t         state;
	cnt_t               cnt;
	cnt_t               nxt_cnt;
	cnt_t               init_pos;  // position inside the init sequence
	logic               init_e;
	lcd_pkg::lcd_data_t init_data;

	assign nxt_cnt = cnt + 1'b1;

	// enable and data pattern of the init sequence
	always_comb begin
		init_pos = (state == drv_init) ? nxt_cnt : '0;
		init_e = 1'b0;
		init_data = '0;
		if (init_pos < t_fset_end) begin
			init_e = 1'b1;
			init_data = fset_cmd;
		end else if (init_pos >= t_gap1_end && init_pos < t_ctrl_end) begin
			init_e = 1'b1;
			init_data = ctrl_cmd;
		end else if (init_pos >= t_gap2_end && init_pos < t_clr_end) begin
			init_e = 1'b1;
			init_data = lcd_pkg::cmd_clear;
		end else if (init_pos >= t_gap3_end && init_pos < t_entry_end) begin
			init_e = 1'b1;
			init_data = entry_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= drv_power_up;
			cnt <= '0;
			busy <= 1'b1;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= '0;
		end else begin
			case (state)
			drv_power_up: begin
				if (cnt == t_power - 1'b1) begin // supply settled
					cnt <= '0;
					e <= init_e;
					lcd_data <= init_data;
					state <= drv_init;
				end else begin
					cnt <= nxt_cnt;
				end
			end
			drv_init: begin
				if (nxt_cnt == t_init_end) begin
					cnt <= '0;
					busy <= 1'b0;
					e <= 1'b0;
					lcd_data <= '0;
					state <= drv_ready;
				end else begin
					cnt <= nxt_cnt;
					e <= init_e;
					lcd_data <= init_data;
				end
			end
			drv_ready: begin
				cnt <= '0;
				if (lcd_enable) begin
					busy <= 1'b1;
					rs <= lcd_bus[9];
					rw <= lcd_bus[8];
					lcd_data <= lcd_bus[7:0];
					state <= drv_write;
				end else begin
					rs <= 1'b0;
					rw <= 1'b0;
					lcd_data <= '0;
				end
			end
			drv_write: begin
				if (cnt == t_write_end) begin // execution time over
					cnt <= '0;
					busy <= 1'b0;
					e <= 1'b0;
					state <= drv_ready;
				end else begin
					cnt <= nxt_cnt;
					e <= (nxt_cnt >= t_e_rise) && (nxt_cnt < t_e_fall);
				end
			end
			endcase
		end
	end

endmodule

/* source/lcd_char_port.sv */
`timescale 1ns/1ps

module lcd_char_port (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req,
	input  lcd_pkg::row_t      row,
	input  lcd_pkg::col_t      col,
	input  lcd_pkg::char_t     ch,
	output logic               ack,
	output logic               word_req,
	output lcd_pkg::lcd_word_t word,
	output logic               last,
	input  logic               word_ack
);

	typedef enum logic [2:0] {
		port_idle,
		port_addr,     // address word offered
		port_addr_rel, // waiting for word_ack to drop
		port_data,     // character word offered
		port_data_rel,
		port_done      // ack held until req drops
	} port_state_t;

	port_state_t          state;
	lcd_pkg::ddram_addr_t addr;
	lcd_pkg::char_t       ch_q;

	assign addr = row ? lcd_pkg::line1_base + lcd_pkg::ddram_addr_t'(col)
		: lcd_pkg::ddram_addr_t'(col);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= port_idle;
			ack <= 1'b0;
			word_req <= 1'b0;
			last <= 1'b0;
		end else begin
			case (state)
			port_idle: begin
				if (req) begin
					word_req <= 1'b1;
					last <= 1'b0;
					state <= port_addr;
				end
			end
			port_addr: begin
				if (word_ack) begin
					word_req <= 1'b0;
					state <= port_addr_rel;
				end
			end
			port_addr_rel: begin
				if (!word_ack) begin
					word_req <= 1'b1;
					last <= 1'b1; // character closes the transaction
					state <= port_data;
				end
			end
			port_data: begin
				if (word_ack) begin
					word_req <= 1'b0;
					state <= port_data_rel;
				end
			end
			port_data_rel: begin
				if (!word_ack) begin
					ack <= 1'b1;
					state <= port_done;
				end
			end
			port_done: begin
				if (!req) begin
					ack <= 1'b0;
					state <= port_idle;
				end
			end
			default: state <= port_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == port_idle && req) begin
			word <= {2'b00, lcd_pkg::cmd_set_ddram | {1'b0, addr}};
			ch_q <= ch;
		end else if (state == port_addr_rel && !word_ack) begin
			word <= {2'b10, ch_q}; // rs=1 data write
		end
	end

endmodule

/* source/lcd_arbiter.sv */
`timescale 1ns/1ps

module lcd_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [1:0]         word_req,
	input  lcd_pkg::lcd_word_t word0,
	input  lcd_pkg::lcd_word_t word1,
	input  logic [1:0]         last,
	output logic [1:0]         word_ack,
	input  logic               busy,
	output logic               lcd_enable,
	output lcd_pkg::lcd_word_t lcd_bus
);

	arb_pkg::arb_state_t state;
	arb_pkg::client_t    grant;
	arb_pkg::client_t    prio;      // client served first on a tie
	arb_pkg::client_t    pick;
	logic                word_last; // current word closes the transaction

	assign pick = word_req[prio] ? prio : ~prio;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= arb_pkg::arb_idle;
			grant <= 1'b0;
			prio <= 1'b0;
			word_last <= 1'b0;
			word_ack <= 2'b00;
			lcd_enable <= 1'b0;
		end else begin
			case (state)
			arb_pkg::arb_idle: begin
				if (|word_req) begin
					grant <= pick;
					state <= arb_pkg::arb_grant;
				end
			end
			arb_pkg::arb_grant: begin
				if (word_req[grant] && !busy) begin
					lcd_enable <= 1'b1; // single cycle pulse
					word_last <= last[grant];
					state <= arb_pkg::arb_issue;
				end
			end
			arb_pkg::arb_issue: begin
				lcd_enable <= 1'b0;
				if (busy)
					state <= arb_pkg::arb_wait;
			end
			arb_pkg::arb_wait: begin
				if (!busy) begin
					word_ack[grant] <= 1'b1;
					state <= arb_pkg::arb_release;
				end
			end
			arb_pkg::arb_release: begin
				if (!word_req[grant]) begin
					word_ack[grant] <= 1'b0;
					if (word_last) begin
						prio <= ~grant; // round robin
						state <= arb_pkg::arb_idle;
					end else begin
						state <= arb_pkg::arb_grant;
					end
				end
			end
			default: state <= arb_pkg::arb_idle;
			endcase
		end
	end

	// bus word follows the enable pulse
	always_ff @(posedge clk) begin
		if (state == arb_pkg::arb_grant && word_req[grant] && !busy)
			lcd_bus <= grant ? word1 : word0;
	end

endmodule

/* source/lcd_subsys.sv */
`timescale 1ns/1ps

module lcd_subsys #(
	parameter int                   clk_per_us = 50,
	parameter lcd_pkg::init_flags_t init_flags = 7'b1010010
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req0,
	input  logic               req1,
	input  lcd_pkg::row_t      row0,
	input  lcd_pkg::row_t      row1,
	input  lcd_pkg::col_t      col0,
	input  lcd_pkg::col_t      col1,
	input  lcd_pkg::char_t     ch0,
	input  lcd_pkg::char_t     ch1,
	output logic               ack0,
	output logic               ack1,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output lcd_pkg::lcd_data_t lcd_data
);

	logic [1:0]         word_req;
	logic [1:0]         word_ack;
	logic [1:0]         last;
	lcd_pkg::lcd_word_t word0;
	lcd_pkg::lcd_word_t word1;
	logic               lcd_enable;
	lcd_pkg::lcd_word_t lcd_bus;
	logic               busy;

	lcd_char_port u_port0 (
		.clk(clk), .rst_n(rst_n),
		.req(req0), .row(row0), .col(col0), .ch(ch0), .ack(ack0),
		.word_req(word_req[0]), .word(word0), .last(last[0]), .word_ack(word_ack[0])
	);

	lcd_char_port u_port1 (
		.clk(clk), .rst_n(rst_n),
		.req(req1), .row(row1), .col(col1), .ch(ch1), .ack(ack1),
		.word_req(word_req[1]), .word(word1), .last(last[1]), .word_ack(word_ack[1])
	);

	lcd_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n),
		.word_req(word_req), .word0(word0), .word1(word1), .last(last),
		.word_ack(word_ack), .busy(busy), .lcd_enable(lcd_enable), .lcd_bus(lcd_bus)
	);

	lcd_driver #(
		.clk_per_us(clk_per_us),
		.init_flags(init_flags)
	) u_driver (
		.clk(clk), .rst_n(rst_n),
		.lcd_enable(lcd_enable), .lcd_bus(lcd_bus), .busy(busy),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

endmodule

/* sim/lcd_subsys_properties.sv */
`timescale 1ns/1ps

module lcd_subsys_properties #(
	parameter bit on_driver = 1'b1
) (
	input logic       clk,
	input logic       rst_n,
	input logic       lcd_enable,
	input logic       busy,
	input logic [2:0] state,
	input logic       grant
);

	// a word is only offered to an idle driver
	assert property (@(posedge clk) disable iff (!rst_n) lcd_enable |-> !busy)
		else $error("lcd_enable seen while busy is high");

	generate
		if (on_driver) begin : g_driver
			// write (3) hands over to ready (2) and nothing else
			assert property (@(posedge clk) disable iff (!rst_n)
				(state == 3'd3) |=> (state == 3'd3 || state == 3'd2))
				else $error("driver left the write state for a state other than ready");
		end else begin : g_arbiter
			assert property (@(posedge clk) disable iff (!rst_n)
				(state == arb_pkg::arb_issue || state == arb_pkg::arb_wait) |-> $stable(grant))
				else $error("arbiter grant changed while a word was in flight");
		end
	endgenerate

endmodule

bind lcd_driver lcd_subsys_properties #(.on_driver(1'b1)) u_driver_props (
	.clk(clk), .rst_n(rst_n), .lcd_enable(lcd_enable), .busy(busy),
	.state({1'b0, state}), .grant(1'b0)
);

bind lcd_arbiter lcd_subsys_properties #(.on_driver(1'b0)) u_arbiter_props (
	.clk(clk), .rst_n(rst_n), .lcd_enable(lcd_enable), .busy(busy),
	.state(state), .grant(grant)
);

/* sim/lcd_subsys_tb.sv */
`timescale 1ns/1ps

module lcd_subsys_tb;

	localparam int clk_per_us = 2;
	localparam lcd_pkg::init_flags_t init_flags = 7'b1011110; // 2 lines, display, cursor, blink, inc
	localparam int ack_limit = 4000;  // cycles per handshake phase
	localparam int init_limit = 2500; // power-up plus init words
	localparam int drain_limit = 400;

	logic               clk;
	logic               rst_n;
	logic               req0;
	logic               req1;
	lcd_pkg::row_t      row0;
	lcd_pkg::row_t      row1;
	lcd_pkg::col_t      col0;
	lcd_pkg::col_t      col1;
	lcd_pkg::char_t     ch0;
	lcd_pkg::char_t     ch1;
	logic               ack0;
	logic               ack1;
	logic               e;
	logic               rs;
	logic               rw;
	lcd_pkg::lcd_data_t lcd_data;

	lcd_pkg::lcd_word_t cap_q[$]; // words seen on the display bus
	lcd_pkg::lcd_word_t exp_q[$]; // words the model predicts
	logic               e_prev;
	logic               rw_seen;
	logic [31:0]        lfsr;
	logic               prio_model; // client that wins a tie
	int                 errors;
	int                 checks;
	int                 tests;

	lcd_subsys #(
		.clk_per_us(clk_per_us),
		.init_flags(init_flags)
	) u_lcd_subsys (
		.clk(clk), .rst_n(rst_n),
		.req0(req0), .req1(req1), .row0(row0), .row1(row1),
		.col0(col0), .col1(col1), .ch0(ch0), .ch1(ch1),
		.ack0(ack0), .ack1(ack1),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

	always #10 clk = ~clk;

	// capture on the rising edge of e, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (e && !e_prev)
				cap_q.push_back({rs, rw, lcd_data});
			if (rw)
				rw_seen = 1'b1; // sticky
		end
		e_prev = e;
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32+x^22+x^2+x+1
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic ack_of(input int client);
		return (client == 0) ? ack0 : ack1;
	endfunction

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic pick_fields(output logic row, output logic [5:0] col, output logic [7:0] ch);
		row = take_bits(1);
		col = take_bits(6);
		ch = take_bits(8);
	endtask

	// address command then character write
	task automatic expect_char(input logic row, input logic [5:0] col, input logic [7:0] ch);
		lcd_pkg::lcd_data_t cmd;
		cmd = lcd_pkg::cmd_set_ddram + (row ? 8'(lcd_pkg::line1_base) : 8'h00) + 8'(col);
		exp_q.push_back({2'b00, cmd});
		exp_q.push_back({2'b10, ch});
	endtask

	task automatic send_char(input int client, input logic row, input logic [5:0] col,
		input logic [7:0] ch);
		int n;
		@(negedge clk);
		if (client == 0) begin
			row0 = row;
			col0 = col;
			ch0 = ch;
			req0 = 1'b1;
		end else begin
			row1 = row;
			col1 = col;
			ch1 = ch;
			req1 = 1'b1;
		end
		n = 0;
		while (ack_of(client) !== 1'b1 && n < ack_limit) begin
			@(negedge clk);
			n++;
		end
		if (n >= ack_limit) begin
			errors++;
			$display("client %0d got no ack within %0d cycles", client, ack_limit);
		end
		if (client == 0)
			req0 = 1'b0;
		else
			req1 = 1'b0;
		n = 0;
		while (ack_of(client) !== 1'b0 && n < ack_limit) begin
			@(negedge clk);
			n++;
		end
		if (n >= ack_limit) begin
			errors++;
			$display("client %0d kept ack high after its request dropped", client);
		end
	endtask

	task automatic send_one(input int client);
		logic       row;
		logic [5:0] col;
		logic [7:0] ch;
		pick_fields(row, col, ch);
		expect_char(row, col, ch);
		send_char(client, row, col, ch);
		prio_model = (client == 0); // the other client wins the next tie
	endtask

	task automatic send_both();
		logic       r0;
		logic [5:0] c0;
		logic [7:0] k0;
		logic       r1;
		logic [5:0] c1;
		logic [7:0] k1;
		pick_fields(r0, c0, k0);
		pick_fields(r1, c1, k1);
		if (prio_model == 1'b0) begin
			expect_char(r0, c0, k0);
			expect_char(r1, c1, k1);
		end else begin
			expect_char(r1, c1, k1);
			expect_char(r0, c0, k0);
		end
		fork
			send_char(0, r0, c0, k0);
			send_char(1, r1, c1, k1);
		join
		// two grants in a row, so priority ends where it started
	endtask

	task automatic check_stream(input string name, input int limit);
		int n;
		n = 0;
		while (cap_q.size() < exp_q.size() && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (cap_q.size() < exp_q.size()) begin
			errors++;
			$display("%s: only %0d of %0d bus words arrived", name, cap_q.size(), exp_q.size());
		end
		while (exp_q.size() > 0 && cap_q.size() > 0)
			check(name, exp_q.pop_front(), cap_q.pop_front());
		if (cap_q.size() > 0) begin
			errors++;
			$display("%s: %0d bus words more than expected", name, cap_q.size());
		end
		cap_q.delete();
		exp_q.delete();
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		$display("test %s: %s", name, (errors == errors_before) ? "ok" : "errors found");
	endtask

	initial begin
		lcd_pkg::lcd_data_t fset;
		lcd_pkg::lcd_data_t ctrl;
		lcd_pkg::lcd_data_t entry;
		int                 start;
		logic [1:0]         sel;
		logic               row;
		logic [5:0]         col;
		logic [7:0]         ch;
		clk = 1'b0;
		rst_n = 1'b0;
		req0 = 1'b0;
		req1 = 1'b0;
		row0 = '0;
		row1 = '0;
		col0 = '0;
		col1 = '0;
		ch0 = '0;
		ch1 = '0;
		e_prev = 1'b0;
		rw_seen = 1'b0;
		lfsr = 32'h0140_91fe;
		prio_model = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		start = errors;
		fset = lcd_pkg::cmd_function_set | (8'(init_flags[6]) << 3) | (8'(init_flags[5]) << 2);
		ctrl = lcd_pkg::cmd_display_ctrl | (8'(init_flags[4]) << 2) | (8'(init_flags[3]) << 1)
			| 8'(init_flags[2]);
		entry = lcd_pkg::cmd_entry_mode | (8'(init_flags[1]) << 1) | 8'(init_flags[0]);
		exp_q.push_back({2'b00, fset});
		exp_q.push_back({2'b00, ctrl});
		exp_q.push_back({2'b00, lcd_pkg::cmd_clear});
		exp_q.push_back({2'b00, entry});
		check_stream("init", init_limit);
		end_test("init", start);

		start = errors;
		for (int i = 0; i < 3; i++)
			send_one(0);
		check_stream("client0", drain_limit);
		end_test("client0", start);

		start = errors;
		for (int i = 0; i < 4; i++) begin
			pick_fields(row, col, ch);
			row = i[0]; // alternate line 0 and line 1
			expect_char(row, col, ch);
			send_char(1, row, col, ch);
		end
		prio_model = 1'b0;
		check_stream("client1", drain_limit);
		end_test("client1", start);

		start = errors;
		for (int i = 0; i < 2; i++) begin
			send_both();
			send_one(0); // next tie goes to client 1
		end
		check_stream("contention", drain_limit);
		end_test("contention", start);

		start = errors;
		rw_seen = 1'b0;
		for (int i = 0; i < 20; i++) begin
			sel = take_bits(2);
			if (sel == 2'd0)
				send_one(0);
			else if (sel == 2'd1)
				send_one(1);
			else
				send_both();
		end
		check_stream("random", drain_limit);
		check("random rw", 32'd0, {31'd0, rw_seen});
		end_test("random", start);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* lcd_subsys.f */
common/lcd_pkg.sv
common/arb_pkg.sv
lcd_driver/lcd_driver.sv
source/lcd_char_port.sv
source/lcd_arbiter.sv
source/lcd_subsys.sv
sim/lcd_subsys_properties.sv
sim/lcd_subsys_tb.sv
